/* files.f */
+incdir+source
source/pdp8_isa_pkg.sv
source/cpu_ctrl_pkg.sv
source/ctrl_bus_if.sv
source/cpu_controller.sv
source/cpu_datapath.sv
source/mem_access.sv
source/pdp8_core.sv
sim/tb_memory.sv
sim/tb_pdp8_core.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and search the log for the pass message
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f files.f --top-module tb_pdp8_core -o tb_pdp8_core
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_pdp8_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi

/* sim/tb_memory.sv */
////////////////////
// Behavioral 4K-word memory with stall and response delays
////////////////////
`timescale 1ns/1ns

module tb_memory (
  input  logic                clock,
  input  logic                resetN,
  input  logic                req_valid,
  output logic                req_ready,
  input  logic                req_write,
  input  pdp8_isa_pkg::addr_t req_addr,
  input  pdp8_isa_pkg::word_t req_wdata,
  output logic                rsp_valid,
  output pdp8_isa_pkg::word_t rsp_data,
  input  logic [2:0]          ready_wait,
  input  logic [1:0]          rsp_wait,
  input  logic                load_en,
  input  pdp8_isa_pkg::addr_t load_addr,
  input  pdp8_isa_pkg::word_t load_data
);

  typedef enum logic [1:0] {P_IDLE, P_STALL, P_RESPOND} phase_t;

  pdp8_isa_pkg::word_t mem [0:4095];
  phase_t              phase;
  logic [2:0]          count;
  logic                transfer;

  // Zero wait accepts in the first valid cycle
  assign req_ready = (phase == P_IDLE && req_valid && ready_wait == 3'd0) ||
                     (phase == P_STALL && count == 3'd0);
  assign transfer  = req_valid && req_ready;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      phase     <= P_IDLE;
      count     <= '0;
      rsp_valid <= 1'b0;
      rsp_data  <= '0;
    end else begin
      rsp_valid <= 1'b0;
      if (load_en) begin
        mem[load_addr] <= load_data;       // Preload port, used while the CPU is idle
      end
      if (transfer) begin
        if (req_write) begin
          mem[req_addr] <= req_wdata;
        end else begin
          rsp_data <= mem[req_addr];
        end
        count <= {1'b0, rsp_wait};
        phase <= P_RESPOND;
      end else begin
        case (phase)
          P_IDLE: begin
            if (req_valid) begin
              count <= ready_wait - 3'd1;
              phase <= P_STALL;
            end
          end
          P_STALL: count <= count - 3'd1;
          P_RESPOND: begin
            if (count == 3'd0) begin
              rsp_valid <= 1'b1;
              phase     <= P_IDLE;
            end else begin
              count <= count - 3'd1;
            end
          end
          default: phase <= P_IDLE;
        endcase
      end
    end
  end

endmodule

/* sim/tb_pdp8_core.sv */
////////////////////
// Directed tests for the accumulator CPU with a memory model
////////////////////
`timescale 1ns/1ns

module tb_pdp8_core;

  localparam int CLOCK_PERIOD    = 10;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 200;

  localparam logic [2:0] OPC_AND = 3'o0;
  localparam logic [2:0] OPC_TAD = 3'o1;
  localparam logic [2:0] OPC_ISZ = 3'o2;
  localparam logic [2:0] OPC_DCA = 3'o3;
  localparam logic [2:0] OPC_JMS = 3'o4;
  localparam logic [2:0] OPC_JMP = 3'o5;
  localparam pdp8_isa_pkg::word_t HALT_INSN = 12'o7402;

  logic                clock;
  logic                resetN;
  logic                run;
  logic                load_pc;
  pdp8_isa_pkg::word_t sr;
  logic                idle;
  logic                halted;
  pdp8_isa_pkg::word_t ac;
  logic                link;
  pdp8_isa_pkg::addr_t pc;
  logic                mem_req_valid;
  logic                mem_req_ready;
  logic                mem_req_write;
  pdp8_isa_pkg::addr_t mem_req_addr;
  pdp8_isa_pkg::word_t mem_req_wdata;
  logic                mem_rsp_valid;
  pdp8_isa_pkg::word_t mem_rsp_data;

  logic [2:0]          ready_wait;
  logic [1:0]          rsp_wait;
  logic                load_en;
  pdp8_isa_pkg::addr_t load_addr;
  pdp8_isa_pkg::word_t load_data;
  logic                long_stalls;       // Widens the ready delay range
  logic [15:0]         lfsr_state;

  pdp8_core dut_i (
    .clock         (clock),
    .resetN        (resetN),
    .run           (run),
    .load_pc       (load_pc),
    .sr            (sr),
    .idle          (idle),
    .halted        (halted),
    .ac            (ac),
    .link          (link),
    .pc            (pc),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req_write (mem_req_write),
    .mem_req_addr  (mem_req_addr),
    .mem_req_wdata (mem_req_wdata),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_data  (mem_rsp_data)
  );

  tb_memory mem_i (
    .clock      (clock),
    .resetN     (resetN),
    .req_valid  (mem_req_valid),
    .req_ready  (mem_req_ready),
    .req_write  (mem_req_write),
    .req_addr   (mem_req_addr),
    .req_wdata  (mem_req_wdata),
    .rsp_valid  (mem_rsp_valid),
    .rsp_data   (mem_rsp_data),
    .ready_wait (ready_wait),
    .rsp_wait   (rsp_wait),
    .load_en    (load_en),
    .load_addr  (load_addr),
    .load_data  (load_data)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLOCK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles",
             NUM_TESTS * CYCLES_PER_TEST);
    $display("Checks failed");
    $fatal(1, "Watchdog expired");
  end

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [11:0] random_bits(input int unsigned width);
    logic [11:0] value;
    logic        feedback;
    int unsigned i;
    value = '0;
    for (i = 0; i < width; i++) begin
      feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], feedback};
      value      = {value[10:0], feedback};
    end
    return value;
  endfunction

  function automatic pdp8_isa_pkg::word_t encode_mri(input logic [2:0] op, input logic page,
                                                     input pdp8_isa_pkg::addr_t target);
    return {op, 1'b0, page, target[6:0]};
  endfunction

  task automatic check_value(input string test_name, input pdp8_isa_pkg::word_t expected,
                             input pdp8_isa_pkg::word_t actual);
    if (expected !== actual) begin
      $display("FAIL %s: expected %04o, actual %04o", test_name, expected, actual);
      $display("Checks failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic draw_delays();
    logic [11:0] bits;
    bits       = random_bits(long_stalls ? 3 : 2);
    ready_wait = bits[2:0];
    bits       = random_bits(2);
    rsp_wait   = bits[1:0];
  endtask

  task automatic apply_reset();
    resetN = 1'b0;
    repeat (4) @(posedge clock);
    #1;
    resetN = 1'b1;
    @(posedge clock);
    #1;
  endtask

  task automatic write_memory(input pdp8_isa_pkg::addr_t addr, input pdp8_isa_pkg::word_t data);
    load_en   = 1'b1;
    load_addr = addr;
    load_data = data;
    @(posedge clock);
    #1;
    load_en   = 1'b0;
  endtask

  task automatic load_program_counter(input pdp8_isa_pkg::word_t value);
    sr      = value;
    load_pc = 1'b1;
    @(posedge clock);
    #1;
    load_pc = 1'b0;
    while (!idle) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic run_until_halt(input pdp8_isa_pkg::addr_t start);
    load_program_counter(start);
    draw_delays();
    run = 1'b1;
    @(posedge clock);
    #1;
    run = 1'b0;
    while (!(idle && halted)) begin
      @(posedge clock);
      #1;
      draw_delays();
    end
  endtask

  // TAD A, TAD B, DCA C, TAD C, AND D, halt with operands at data..data+3
  task automatic load_add_program(input pdp8_isa_pkg::addr_t base,
                                  input pdp8_isa_pkg::addr_t data, input logic page,
                                  output pdp8_isa_pkg::word_t a, output pdp8_isa_pkg::word_t b,
                                  output pdp8_isa_pkg::word_t d);
    a = random_bits(12);
    b = random_bits(12);
    d = random_bits(12);
    write_memory(data, a);
    write_memory(data + 12'd1, b);
    write_memory(data + 12'd2, 12'o0000);
    write_memory(data + 12'd3, d);
    write_memory(base, encode_mri(OPC_TAD, page, data));
    write_memory(base + 12'd1, encode_mri(OPC_TAD, page, data + 12'd1));
    write_memory(base + 12'd2, encode_mri(OPC_DCA, page, data + 12'd2));
    write_memory(base + 12'd3, encode_mri(OPC_TAD, page, data + 12'd2));
    write_memory(base + 12'd4, encode_mri(OPC_AND, page, data + 12'd3));
    write_memory(base + 12'd5, HALT_INSN);
  endtask

  task automatic check_add_program(input string name, input pdp8_isa_pkg::word_t a,
                                   input pdp8_isa_pkg::word_t b, input pdp8_isa_pkg::word_t d,
                                   input pdp8_isa_pkg::addr_t c_addr,
                                   input pdp8_isa_pkg::addr_t halt_addr);
    logic [12:0] sum;
    sum = {1'b0, a} + {1'b0, b};
    check_value({name, " ac"}, sum[11:0] & d, ac);
    check_value({name, " link"}, {11'd0, sum[12]}, {11'd0, link});
    check_value({name, " stored sum"}, sum[11:0], mem_i.mem[c_addr]);
    check_value({name, " pc"}, halt_addr + 12'd1, pc);
  endtask

  task automatic test_reset_and_load();
    pdp8_isa_pkg::word_t value;
    apply_reset();
    check_value("reset idle", 12'd1, {11'd0, idle});
    check_value("reset halted", 12'd0, {11'd0, halted});
    check_value("reset ac", 12'd0, ac);
    check_value("reset link", 12'd0, {11'd0, link});
    check_value("reset request valid", 12'd0, {11'd0, mem_req_valid});
    value = random_bits(12);
    load_program_counter(value);
    check_value("load pc", value, pc);
  endtask

  task automatic test_add_and_store();
    pdp8_isa_pkg::word_t a;
    pdp8_isa_pkg::word_t b;
    pdp8_isa_pkg::word_t d;
    apply_reset();
    load_add_program(12'o0200, 12'o0240, 1'b1, a, b, d);   // Current-page operands
    run_until_halt(12'o0200);
    check_add_program("add and store", a, b, d, 12'o0242, 12'o0205);
  endtask

  task automatic test_isz_skip();
    pdp8_isa_pkg::word_t skipped_val;
    pdp8_isa_pkg::word_t added_val;
    pdp8_isa_pkg::word_t count_val;
    apply_reset();
    skipped_val = random_bits(12) | 12'd1;
    added_val   = random_bits(12) | 12'd1;
    count_val   = random_bits(12);
    if (count_val == 12'o7777) begin
      count_val = 12'o7776;
    end
    write_memory(12'o0050, 12'o7777);
    write_memory(12'o0051, count_val);
    write_memory(12'o0052, skipped_val);
    write_memory(12'o0053, added_val);
    write_memory(12'o0400, encode_mri(OPC_ISZ, 1'b0, 12'o0050));
    write_memory(12'o0401, encode_mri(OPC_TAD, 1'b0, 12'o0052));   // Skipped
    write_memory(12'o0402, encode_mri(OPC_ISZ, 1'b0, 12'o0051));
    write_memory(12'o0403, encode_mri(OPC_TAD, 1'b0, 12'o0053));
    write_memory(12'o0404, HALT_INSN);
    run_until_halt(12'o0400);
    check_value("isz wrap word", 12'o0000, mem_i.mem[12'o0050]);
    check_value("isz count word", count_val + 12'd1, mem_i.mem[12'o0051]);
    check_value("isz ac", added_val, ac);
    check_value("isz pc", 12'o0405, pc);
  endtask

  task automatic test_jump_subroutine();
    pdp8_isa_pkg::word_t value;
    apply_reset();
    value = random_bits(12) | 12'd1;
    write_memory(12'o0060, value);
    write_memory(12'o0070, HALT_INSN);                             // Halt on page 0
    write_memory(12'o1000, encode_mri(OPC_JMP, 1'b1, 12'o1020));
    write_memory(12'o1001, HALT_INSN);
    write_memory(12'o1020, encode_mri(OPC_JMS, 1'b1, 12'o1050));
    write_memory(12'o1021, HALT_INSN);
    write_memory(12'o1050, 12'o0000);                              // Return slot
    write_memory(12'o1051, encode_mri(OPC_TAD, 1'b0, 12'o0060));
    write_memory(12'o1052, encode_mri(OPC_JMP, 1'b0, 12'o0070));
    run_until_halt(12'o1000);
    check_value("jms return word", 12'o1021, mem_i.mem[12'o1050]);
    check_value("jms ac", value, ac);
    check_value("jmp pc", 12'o0071, pc);
  endtask

  task automatic test_stall_and_noop();
    pdp8_isa_pkg::word_t a;
    pdp8_isa_pkg::word_t b;
    pdp8_isa_pkg::word_t d;
    apply_reset();
    long_stalls = 1'b1;
    write_memory(12'o0104, 12'o0123);
    write_memory(12'o2000, 12'o6031);                                      // IOT
    write_memory(12'o2001, encode_mri(OPC_TAD, 1'b0, 12'o0104) | 12'o0400); // Indirect
    load_add_program(12'o2002, 12'o0100, 1'b0, a, b, d);
    run_until_halt(12'o2000);
    long_stalls = 1'b0;
    check_add_program("stall and noop", a, b, d, 12'o0102, 12'o2007);
  endtask

  initial begin
    resetN      = 1'b0;
    run         = 1'b0;
    load_pc     = 1'b0;
    sr          = '0;
    load_en     = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    ready_wait  = '0;
    rsp_wait    = '0;
    long_stalls = 1'b0;
    lfsr_state  = 16'd61554;
    test_reset_and_load();
    test_add_and_store();
    test_isz_skip();
    test_jump_subroutine();
    test_stall_and_noop();
    $display("All checks passed");
    $finish;
  end

endmodule

/* source/cpu_controller.sv */
////////////////////
// Moore FSM for fetch, decode and memory-reference execution
////////////////////
`timescale 1ns/1ns
`include "cpu_params.svh"

module cpu_controller (
  input  logic          clock,
  input  logic          resetN,
  input  logic          run,
  input  logic          load_pc,
  ctrl_bus_if.controller bus,
  output logic          mem_start,
  output logic          mem_write,
  input  logic          mem_done,
  output logic          idle,
  output logic          halted
);

  localparam pdp8_isa_pkg::word_t HALT_INSN = `HALT_WORD;

  cpu_ctrl_pkg::ctrl_state_t state;
  cpu_ctrl_pkg::ctrl_state_t next_state;
  logic                      is_halt;
  logic                      is_mri;
  logic                      in_wait;

  // Opcode, indirect and page bits cover IR[11:7] of the halt word
  assign is_halt = ({bus.opcode, bus.indirect, bus.page_bit} ==
                    HALT_INSN[`WORD_WIDTH-1:`OFFSET_WIDTH]);
  assign is_mri  = (bus.opcode != pdp8_isa_pkg::OP_IOT) &&
                   (bus.opcode != pdp8_isa_pkg::OP_OPR) && !bus.indirect;
  assign in_wait = (state == cpu_ctrl_pkg::FETCH_3) || (state == cpu_ctrl_pkg::RD_3) ||
                   (state == cpu_ctrl_pkg::WR_2);

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state <= cpu_ctrl_pkg::REG_INIT;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      cpu_ctrl_pkg::REG_INIT: next_state = cpu_ctrl_pkg::CPU_IDLE;
      cpu_ctrl_pkg::CPU_IDLE: begin
        if (run) begin
          next_state = cpu_ctrl_pkg::FETCH_1;
        end else if (load_pc) begin
          next_state = cpu_ctrl_pkg::LD_PC_1;
        end
      end
      cpu_ctrl_pkg::LD_PC_1: next_state = cpu_ctrl_pkg::LD_PC_2;
      cpu_ctrl_pkg::LD_PC_2: next_state = cpu_ctrl_pkg::CPU_IDLE;
      cpu_ctrl_pkg::FETCH_1: next_state = cpu_ctrl_pkg::FETCH_2;
      cpu_ctrl_pkg::FETCH_2: next_state = cpu_ctrl_pkg::FETCH_3;
      cpu_ctrl_pkg::FETCH_3: if (mem_done) next_state = cpu_ctrl_pkg::DECODE;
      cpu_ctrl_pkg::DECODE: begin
        if (is_halt) begin
          next_state = cpu_ctrl_pkg::HALT;
        end else if (is_mri) begin
          next_state = cpu_ctrl_pkg::CAL_EA;
        end else begin
          next_state = cpu_ctrl_pkg::NOP_1;           // IOT, operate, indirect forms
        end
      end
      cpu_ctrl_pkg::CAL_EA: begin
        case (bus.opcode)
          pdp8_isa_pkg::OP_JMP: next_state = cpu_ctrl_pkg::JMP_X;
          pdp8_isa_pkg::OP_DCA: next_state = cpu_ctrl_pkg::DCA_1;
          pdp8_isa_pkg::OP_JMS: next_state = cpu_ctrl_pkg::JMS_1;
          default:              next_state = cpu_ctrl_pkg::RD_1;
        endcase
      end
      cpu_ctrl_pkg::RD_1: next_state = cpu_ctrl_pkg::RD_2;
      cpu_ctrl_pkg::RD_2: next_state = cpu_ctrl_pkg::RD_3;
      cpu_ctrl_pkg::RD_3: begin
        if (mem_done) begin
          case (bus.opcode)
            pdp8_isa_pkg::OP_AND: next_state = cpu_ctrl_pkg::AND_X;
            pdp8_isa_pkg::OP_TAD: next_state = cpu_ctrl_pkg::TAD_X;
            default:              next_state = cpu_ctrl_pkg::ISZ_INC;
          endcase
        end
      end
      cpu_ctrl_pkg::ISZ_INC: next_state = cpu_ctrl_pkg::ISZ_WD;
      cpu_ctrl_pkg::ISZ_WD:  next_state = cpu_ctrl_pkg::WR_1;
      cpu_ctrl_pkg::DCA_1:   next_state = cpu_ctrl_pkg::WR_1;
      cpu_ctrl_pkg::JMS_1:   next_state = cpu_ctrl_pkg::WR_1;
      cpu_ctrl_pkg::WR_1:    next_state = cpu_ctrl_pkg::WR_2;
      cpu_ctrl_pkg::WR_2: begin
        if (mem_done) begin
          case (bus.opcode)
            pdp8_isa_pkg::OP_DCA: next_state = cpu_ctrl_pkg::DCA_X;
            pdp8_isa_pkg::OP_JMS: next_state = cpu_ctrl_pkg::JMS_X;
            default: next_state = bus.mb_zero ? cpu_ctrl_pkg::ISZ_SKIP : cpu_ctrl_pkg::NOP_1;
          endcase
        end
      end
      cpu_ctrl_pkg::HALT: next_state = cpu_ctrl_pkg::CPU_IDLE;
      default:            next_state = cpu_ctrl_pkg::FETCH_1;   // Execute states run on
    endcase
  end

  always_comb begin
    bus.ac_ctrl    = cpu_ctrl_pkg::AC_NC;
    bus.pc_ctrl    = cpu_ctrl_pkg::PC_NC;
    bus.mb_ctrl    = cpu_ctrl_pkg::MB_NC;
    bus.ea_ctrl    = cpu_ctrl_pkg::EA_NC;
    bus.ad_ctrl    = cpu_ctrl_pkg::AD_NC;
    bus.wd_ctrl    = cpu_ctrl_pkg::WD_NC;
    bus.ir_load    = 1'b0;
    bus.link_clear = 1'b0;
    mem_start      = 1'b0;
    mem_write      = 1'b0;
    case (state)
      cpu_ctrl_pkg::REG_INIT: begin
        bus.ac_ctrl    = cpu_ctrl_pkg::AC_CLEAR;
        bus.link_clear = 1'b1;
        bus.mb_ctrl    = cpu_ctrl_pkg::MB_ZERO;
        bus.ea_ctrl    = cpu_ctrl_pkg::EA_ZERO;
      end
      cpu_ctrl_pkg::LD_PC_1:  bus.pc_ctrl = cpu_ctrl_pkg::PC_SR;
      cpu_ctrl_pkg::FETCH_1:  bus.ad_ctrl = cpu_ctrl_pkg::AD_PC;
      cpu_ctrl_pkg::FETCH_3:  bus.ir_load = 1'b1;        // Last load lands on mem_done
      cpu_ctrl_pkg::CAL_EA:
        bus.ea_ctrl = bus.page_bit ? cpu_ctrl_pkg::EA_CP : cpu_ctrl_pkg::EA_ZP;
      cpu_ctrl_pkg::RD_1:     bus.ad_ctrl = cpu_ctrl_pkg::AD_EA;
      cpu_ctrl_pkg::RD_3:     bus.mb_ctrl = cpu_ctrl_pkg::MB_RD;
      cpu_ctrl_pkg::ISZ_INC:  bus.mb_ctrl = cpu_ctrl_pkg::MB_INC;
      cpu_ctrl_pkg::ISZ_WD:   bus.wd_ctrl = cpu_ctrl_pkg::WD_MB;   // Address still EA
      cpu_ctrl_pkg::DCA_1: begin
        bus.ad_ctrl = cpu_ctrl_pkg::AD_EA;
        bus.wd_ctrl = cpu_ctrl_pkg::WD_AC;
      end
      cpu_ctrl_pkg::JMS_1: begin
        bus.ad_ctrl = cpu_ctrl_pkg::AD_EA;
        bus.wd_ctrl = cpu_ctrl_pkg::WD_PCP1;
      end
      cpu_ctrl_pkg::RD_2, cpu_ctrl_pkg::FETCH_2: mem_start = 1'b1;
      cpu_ctrl_pkg::WR_1: begin
        mem_start = 1'b1;
        mem_write = 1'b1;
      end
      cpu_ctrl_pkg::AND_X: begin
        bus.ac_ctrl = cpu_ctrl_pkg::AC_AND;
        bus.pc_ctrl = cpu_ctrl_pkg::PC_P1;
      end
      cpu_ctrl_pkg::TAD_X: begin
        bus.ac_ctrl = cpu_ctrl_pkg::AC_TAD;
        bus.pc_ctrl = cpu_ctrl_pkg::PC_P1;
      end
      cpu_ctrl_pkg::DCA_X: begin
        bus.ac_ctrl = cpu_ctrl_pkg::AC_CLEAR;
        bus.pc_ctrl = cpu_ctrl_pkg::PC_P1;
      end
      cpu_ctrl_pkg::ISZ_SKIP: bus.pc_ctrl = cpu_ctrl_pkg::PC_P2;
      cpu_ctrl_pkg::JMS_X:    bus.pc_ctrl = cpu_ctrl_pkg::PC_EAP1;
      cpu_ctrl_pkg::JMP_X:    bus.pc_ctrl = cpu_ctrl_pkg::PC_JMP;
      cpu_ctrl_pkg::NOP_1, cpu_ctrl_pkg::HALT: bus.pc_ctrl = cpu_ctrl_pkg::PC_P1;
      default: ;
    endcase
  end

  assign idle = (state == cpu_ctrl_pkg::CPU_IDLE);

  // Set on leaving HALT, so it rises with idle
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      halted <= 1'b0;
    end else if (state == cpu_ctrl_pkg::HALT) begin
      halted <= 1'b1;
    end else if (idle && run) begin
      halted <= 1'b0;
    end
  end

  // A completion from the memory unit only arrives while a wait state holds
  a_done_in_wait: assert property (@(posedge clock) disable iff (!resetN)
    mem_done |-> in_wait);

endmodule

/* source/cpu_ctrl_pkg.sv */
////////////////////
// Controller states and datapath register control codes
////////////////////
package cpu_ctrl_pkg;

  typedef enum logic [4:0] {
    REG_INIT, CPU_IDLE, LD_PC_1, LD_PC_2,
    FETCH_1, FETCH_2, FETCH_3, DECODE, CAL_EA,
    NOP_1, HALT,
    RD_1, RD_2, RD_3, AND_X, TAD_X,
    ISZ_INC, ISZ_WD, ISZ_SKIP,
    DCA_1, JMS_1, WR_1, WR_2,
    DCA_X, JMS_X, JMP_X
  } ctrl_state_t;

  typedef enum logic [1:0] {AC_NC, AC_CLEAR, AC_AND, AC_TAD} ac_ctrl_t;

  typedef enum logic [2:0] {PC_NC, PC_P1, PC_P2, PC_JMP, PC_SR, PC_EAP1} pc_ctrl_t;

  typedef enum logic [1:0] {MB_NC, MB_ZERO, MB_RD, MB_INC} mb_ctrl_t;

  typedef enum logic [1:0] {EA_NC, EA_ZERO, EA_ZP, EA_CP} ea_ctrl_t;

  typedef enum logic [1:0] {AD_NC, AD_PC, AD_EA} ad_ctrl_t;

  typedef enum logic [1:0] {WD_NC, WD_AC, WD_MB, WD_PCP1} wd_ctrl_t;

endpackage

/* source/cpu_datapath.sv */
////////////////////
// AC, link, PC, IR, MB and EA registers, memory address and write data
////////////////////
`timescale 1ns/1ns
`include "cpu_params.svh"

module cpu_datapath (
  input  logic                clock,
  input  logic                resetN,
  input  pdp8_isa_pkg::word_t sr,
  input  pdp8_isa_pkg::word_t mem_rdata,
  ctrl_bus_if.datapath        bus,
  output pdp8_isa_pkg::addr_t mem_addr,
  output pdp8_isa_pkg::word_t mem_wdata,
  output pdp8_isa_pkg::word_t ac,
  output logic                link,
  output pdp8_isa_pkg::addr_t pc
);

  pdp8_isa_pkg::word_t  ir;
  pdp8_isa_pkg::word_t  mb;
  pdp8_isa_pkg::addr_t  ea;
  pdp8_isa_pkg::word_t  rdata_q;
  logic [`WORD_WIDTH:0] tad_sum;

  assign tad_sum = {1'b0, ac} + {1'b0, mb};

  // Response data is one cycle old when mem_done reaches the FSM
  always_ff @(posedge clock) begin
    rdata_q <= mem_rdata;
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      ac   <= '0;
      link <= 1'b0;
    end else begin
      case (bus.ac_ctrl)
        cpu_ctrl_pkg::AC_CLEAR: ac <= '0;
        cpu_ctrl_pkg::AC_AND:   ac <= ac & mb;
        cpu_ctrl_pkg::AC_TAD:   ac <= tad_sum[`WORD_WIDTH-1:0];
        default: ;
      endcase
      if (bus.link_clear) begin
        link <= 1'b0;
      end else if (bus.ac_ctrl == cpu_ctrl_pkg::AC_TAD) begin
        link <= link ^ tad_sum[`WORD_WIDTH];            // Carry complements link
      end
    end
  end

  // PC survives reset, front panel sets it
  always_ff @(posedge clock) begin
    case (bus.pc_ctrl)
      cpu_ctrl_pkg::PC_P1:   pc <= pc + 1'b1;
      cpu_ctrl_pkg::PC_P2:   pc <= pc + 2'd2;
      cpu_ctrl_pkg::PC_JMP:  pc <= ea;
      cpu_ctrl_pkg::PC_SR:   pc <= sr;
      cpu_ctrl_pkg::PC_EAP1: pc <= ea + 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      ir <= '0;
      mb <= '0;
      ea <= '0;
    end else begin
      if (bus.ir_load) begin
        ir <= rdata_q;
      end
      case (bus.mb_ctrl)
        cpu_ctrl_pkg::MB_ZERO: mb <= '0;
        cpu_ctrl_pkg::MB_RD:   mb <= rdata_q;
        cpu_ctrl_pkg::MB_INC:  mb <= mb + 1'b1;
        default: ;
      endcase
      case (bus.ea_ctrl)
        cpu_ctrl_pkg::EA_ZERO: ea <= '0;
        cpu_ctrl_pkg::EA_ZP:   ea <= {{(`WORD_WIDTH-`OFFSET_WIDTH){1'b0}},
                                      ir[`OFFSET_WIDTH-1:0]};
        cpu_ctrl_pkg::EA_CP:   ea <= {pc[`WORD_WIDTH-1:`OFFSET_WIDTH],
                                      ir[`OFFSET_WIDTH-1:0]};
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    case (bus.ad_ctrl)
      cpu_ctrl_pkg::AD_PC: mem_addr <= pc;
      cpu_ctrl_pkg::AD_EA: mem_addr <= ea;
      default: ;
    endcase
    case (bus.wd_ctrl)
      cpu_ctrl_pkg::WD_AC:   mem_wdata <= ac;
      cpu_ctrl_pkg::WD_MB:   mem_wdata <= mb;
      cpu_ctrl_pkg::WD_PCP1: mem_wdata <= pc + 1'b1;   // JMS return address
      default: ;
    endcase
  end

  assign bus.opcode   = pdp8_isa_pkg::opcode_t'(ir[`WORD_WIDTH-1:`OPCODE_LSB]);
  assign bus.indirect = ir[`OFFSET_WIDTH+1];
  assign bus.page_bit = ir[`OFFSET_WIDTH];
  assign bus.mb_zero  = (mb == '0);

  // Both take the same response word
  a_ir_mb_exclusive: assert property (@(posedge clock) disable iff (!resetN)
    !(bus.ir_load && (bus.mb_ctrl == cpu_ctrl_pkg::MB_RD)));

endmodule

/* source/cpu_params.svh */
////////////////////
// Word, page offset and opcode field sizes, halt instruction code
////////////////////
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define WORD_WIDTH   12         // Data word and address width
`define OFFSET_WIDTH 7          // Page offset bits within an instruction
`define OPCODE_LSB   9          // Opcode occupies bits 11..9
`define HALT_WORD    12'o7402   // Operate group 2 HLT

`endif

/* source/ctrl_bus_if.sv */
////////////////////
// Register controls and decoded status between controller and datapath
////////////////////
`timescale 1ns/1ns

interface ctrl_bus_if;
  cpu_ctrl_pkg::ac_ctrl_t ac_ctrl;
  cpu_ctrl_pkg::pc_ctrl_t pc_ctrl;
  cpu_ctrl_pkg::mb_ctrl_t mb_ctrl;
  cpu_ctrl_pkg::ea_ctrl_t ea_ctrl;
  cpu_ctrl_pkg::ad_ctrl_t ad_ctrl;
  cpu_ctrl_pkg::wd_ctrl_t wd_ctrl;
  logic                   ir_load;
  logic                   link_clear;
  pdp8_isa_pkg::opcode_t  opcode;      // IR fields seen by the FSM
  logic                   indirect;
  logic                   page_bit;
  logic                   mb_zero;

  modport controller (
    output ac_ctrl, pc_ctrl, ir_load, mb_ctrl, ea_ctrl, ad_ctrl, wd_ctrl, link_clear,
    input  opcode, indirect, page_bit, mb_zero
  );

  modport datapath (
    input  ac_ctrl, pc_ctrl, ir_load, mb_ctrl, ea_ctrl, ad_ctrl, wd_ctrl, link_clear,
    output opcode, indirect, page_bit, mb_zero
  );
endinterface

/* source/mem_access.sv */
////////////////////
// Single-outstanding memory request and response sequencer
////////////////////
`timescale 1ns/1ns

module mem_access (
  input  logic                clock,
  input  logic                resetN,
  input  logic                mem_start,
  input  logic                mem_write,
  input  pdp8_isa_pkg::addr_t mem_addr,
  input  pdp8_isa_pkg::word_t mem_wdata,
  output logic                mem_done,
  output logic                mem_req_valid,
  input  logic                mem_req_ready,
  output logic                mem_req_write,
  output pdp8_isa_pkg::addr_t mem_req_addr,
  output pdp8_isa_pkg::word_t mem_req_wdata,
  input  logic                mem_rsp_valid
);

  typedef enum logic [1:0] {M_IDLE, M_REQ, M_RSP} mem_state_t;

  mem_state_t state;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state         <= M_IDLE;
      mem_done      <= 1'b0;
      mem_req_write <= 1'b0;
    end else begin
      mem_done <= 1'b0;
      case (state)
        M_IDLE: begin
          if (mem_start) begin
            state         <= M_REQ;
            mem_req_write <= mem_write;
          end
        end
        M_REQ: if (mem_req_ready) state <= M_RSP;   // Held under back-pressure
        M_RSP: begin
          if (mem_rsp_valid) begin
            state    <= M_IDLE;
            mem_done <= 1'b1;
          end
        end
        default: state <= M_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == M_IDLE && mem_start) begin
      mem_req_addr  <= mem_addr;
      mem_req_wdata <= mem_wdata;
    end
  end

  assign mem_req_valid = (state == M_REQ);

  a_req_stable: assert property (@(posedge clock) disable iff (!resetN)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr) &&
    $stable(mem_req_write) && $stable(mem_req_wdata));

  a_rsp_expected: assert property (@(posedge clock) disable iff (!resetN)
    mem_rsp_valid |-> state == M_RSP);

endmodule

/* source/pdp8_core.sv */
////////////////////
// CPU top level, controller, datapath and memory access
////////////////////
`timescale 1ns/1ns

module pdp8_core (
  input  logic                clock,
  input  logic                resetN,
  input  logic                run,
  input  logic                load_pc,
  input  pdp8_isa_pkg::word_t sr,
  output logic                idle,
  output logic                halted,
  output pdp8_isa_pkg::word_t ac,
  output logic                link,
  output pdp8_isa_pkg::addr_t pc,
  output logic                mem_req_valid,
  input  logic                mem_req_ready,
  output logic                mem_req_write,
  output pdp8_isa_pkg::addr_t mem_req_addr,
  output pdp8_isa_pkg::word_t mem_req_wdata,
  input  logic                mem_rsp_valid,
  input  pdp8_isa_pkg::word_t mem_rsp_data
);

  logic                mem_start;
  logic                mem_write;
  logic                mem_done;
  pdp8_isa_pkg::addr_t mem_addr;
  pdp8_isa_pkg::word_t mem_wdata;

  ctrl_bus_if bus_i ();

  cpu_controller ctrl_i (
    .clock     (clock),
    .resetN    (resetN),
    .run       (run),
    .load_pc   (load_pc),
    .bus       (bus_i.controller),
    .mem_start (mem_start),
    .mem_write (mem_write),
    .mem_done  (mem_done),
    .idle      (idle),
    .halted    (halted)
  );

  cpu_datapath dp_i (
    .clock     (clock),
    .resetN    (resetN),
    .sr        (sr),
    .mem_rdata (mem_rsp_data),
    .bus       (bus_i.datapath),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .ac        (ac),
    .link      (link),
    .pc        (pc)
  );

  mem_access mem_i (
    .clock         (clock),
    .resetN        (resetN),
    .mem_start     (mem_start),
    .mem_write     (mem_write),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_done      (mem_done),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req_write (mem_req_write),
    .mem_req_addr  (mem_req_addr),
    .mem_req_wdata (mem_req_wdata),
    .mem_rsp_valid (mem_rsp_valid)
  );

endmodule

/* source/pdp8_isa_pkg.sv */
////////////////////
// Word, address and opcode types of the instruction set
////////////////////
`include "cpu_params.svh"

package pdp8_isa_pkg;

  typedef logic [`WORD_WIDTH-1:0] word_t;
  typedef logic [`WORD_WIDTH-1:0] addr_t;   // 4K word address space

  // Major opcode in IR bits 11..9
  typedef enum logic [2:0] {
    OP_AND = 3'o0,
    OP_TAD = 3'o1,
    OP_ISZ = 3'o2,
    OP_DCA = 3'o3,
    OP_JMS = 3'o4,
    OP_JMP = 3'o5,
    OP_IOT = 3'o6,
    OP_OPR = 3'o7
  } opcode_t;

endpackage
